/* verilog/dcache_consts.svh */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ----------------------------------------------------------------------
// cache geometry
// ----------------------------------------------------------------------
`define DC_XLEN       32    // data and address width
`define DC_BLK_BYTES  16    // bytes per block
`define DC_WAYS       2     // two-way set associative
`define DC_SETS       16

// address split, tag | index | word | byte
`define DC_OFF_BITS   4     // log2 of block bytes
`define DC_IDX_BITS   4     // log2 of sets
`define DC_TAG_BITS   24    // xlen minus index and offset

// ----------------------------------------------------------------------
// burst and line
// ----------------------------------------------------------------------
`define DC_BEATS      4     // words per block, one per bus beat
`define DC_BEAT_BITS  2
`define DC_LINE_BITS  128   // blk_bytes * 8

`define DC_LFSR_BITS  20    // victim pick shift register

`endif

/* verilog/dcache_pkg.sv */
`include "dcache_consts.svh"

package dcache_pkg;

  // one address word, seen flat for the bus or split for the lookup
  typedef union packed {
    logic [`DC_XLEN-1:0] a;                // flat view
    struct packed {
      logic [`DC_TAG_BITS-1:0]  tag;
      logic [`DC_IDX_BITS-1:0]  idx;       // set select
      logic [`DC_BEAT_BITS-1:0] word;      // word within block
      logic [1:0]               byte_off;  // byte within word
    } f;
  } dc_addr_u;

endpackage

/* verilog/dcache_tag_array.sv */
`include "dcache_consts.svh"

module dcache_tag_array (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [`DC_IDX_BITS-1:0]     lookup_idx_i,
  input  logic [`DC_TAG_BITS-1:0]     lookup_tag_i,
  input  logic                        tag_we_i,
  input  logic                        dirty_we_i,
  input  logic                        lfsr_hold_i,
  input  logic [$clog2(`DC_WAYS)-1:0] victim_way_i,   // way written by tag_we
  output logic                        hit_o,
  output logic [$clog2(`DC_WAYS)-1:0] hit_way_o,
  output logic [$clog2(`DC_WAYS)-1:0] victim_way_o,
  output logic                        victim_dirty_o,
  output logic [`DC_TAG_BITS-1:0]     victim_tag_o
);

  localparam int way_w = $clog2(`DC_WAYS);

  logic [`DC_TAG_BITS-1:0]  tag_mem [`DC_WAYS][`DC_SETS];
  logic [`DC_SETS-1:0]      valid_q [`DC_WAYS];   // flops, cleared at reset
  logic [`DC_SETS-1:0]      dirty_q [`DC_WAYS];
  logic [`DC_TAG_BITS-1:0]  tag_rd  [`DC_WAYS];
  dcache_pkg::dc_addr_u     cmp_q;                // registered lookup
  logic [`DC_LFSR_BITS-1:0] lfsr_q;
  logic [way_w-1:0]         victim_q;
  logic [`DC_WAYS-1:0]      way_vld;
  logic [`DC_WAYS-1:0]      way_drt;
  logic [`DC_WAYS-1:0]      way_hit;

  // ----------------------------------------------------------------------
  // tag storage, registered read
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      if (tag_we_i && victim_way_i == way_w'(w))
        tag_mem[w][lookup_idx_i] <= lookup_tag_i;
      tag_rd[w] <= tag_mem[w][lookup_idx_i];   // old value on a write edge
    end
    cmp_q.a <= {lookup_tag_i, lookup_idx_i, {`DC_OFF_BITS{1'b0}}};
  end

  // valid and dirty
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int w = 0; w < `DC_WAYS; w++)
      begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
    end
    else
    begin
      for (int w = 0; w < `DC_WAYS; w++)
      begin
        if (tag_we_i && victim_way_i == way_w'(w))
        begin
          valid_q[w][lookup_idx_i] <= 1'b1;   // fresh block is clean
          dirty_q[w][lookup_idx_i] <= 1'b0;
        end
        else if (dirty_we_i && hit_way_o == way_w'(w))
          dirty_q[w][lookup_idx_i] <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // compare, hit way falls back to victim on a miss
  // ----------------------------------------------------------------------
  always_comb
  begin
    hit_way_o = victim_q;
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      way_vld[w] = valid_q[w][cmp_q.f.idx];
      way_drt[w] = dirty_q[w][cmp_q.f.idx];
      way_hit[w] = way_vld[w] & (tag_rd[w] == cmp_q.f.tag);
      if (way_hit[w])
        hit_way_o = way_w'(w);
    end
  end

  assign hit_o          = |way_hit;
  assign victim_way_o   = victim_q;
  assign victim_dirty_o = way_vld[victim_q] & way_drt[victim_q];
  assign victim_tag_o   = tag_rd[victim_q];

  // free-running pick, frozen for the whole miss
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      lfsr_q   <= '0;                          // xnor taps, zero is legal
      victim_q <= '0;
    end
    else if (!lfsr_hold_i)
    begin
      lfsr_q   <= {lfsr_q[`DC_LFSR_BITS-2:0],
                   lfsr_q[`DC_LFSR_BITS-1] ~^ lfsr_q[`DC_LFSR_BITS-4]};
      victim_q <= lfsr_q[way_w-1:0];
    end
  end

endmodule

/* verilog/dcache_data_array.sv */
`include "dcache_consts.svh"

module dcache_data_array (
  input  logic                        clk_i,
  input  logic [`DC_IDX_BITS-1:0]     idx_i,
  input  logic [$clog2(`DC_WAYS)-1:0] way_i,        // read way
  input  logic [`DC_BEAT_BITS-1:0]    word_off_i,
  input  logic [`DC_XLEN/8-1:0]       be_i,
  input  logic [`DC_XLEN-1:0]         wdata_i,
  input  logic [`DC_WAYS-1:0]         word_we_i,    // one-hot per way
  input  logic [`DC_WAYS-1:0]         line_we_i,
  input  logic [`DC_LINE_BITS-1:0]    line_i,
  output logic [`DC_XLEN-1:0]         rdata_o,
  output logic [`DC_LINE_BITS-1:0]    victim_line_o
);

  logic [`DC_LINE_BITS-1:0] mem_q [`DC_WAYS][`DC_SETS];
  logic [`DC_LINE_BITS-1:0] line_q;               // registered read of way_i

  // ----------------------------------------------------------------------
  // writes, whole line wins over a word
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      if (line_we_i[w])
        mem_q[w][idx_i] <= line_i;
      else if (word_we_i[w])
      begin
        for (int b = 0; b < `DC_XLEN/8; b++)
        begin
          if (be_i[b])                            // byte lanes
            mem_q[w][idx_i][int'(word_off_i)*`DC_XLEN + b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
    line_q <= mem_q[way_i][idx_i];                // read old on a write edge
  end

  // word select, line goes to the burst unit as is
  assign rdata_o       = line_q[int'(word_off_i)*`DC_XLEN +: `DC_XLEN];
  assign victim_line_o = line_q;

endmodule

/* verilog/dcache_burst_unit.sv */
`include "dcache_consts.svh"

module dcache_burst_unit (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // control handshake
  input  logic                     burst_req_i,
  input  logic                     burst_we_i,
  input  logic [`DC_XLEN-1:0]      burst_adr_i,
  input  logic [`DC_LINE_BITS-1:0] victim_line_i,
  output logic                     burst_ack_o,
  output logic [`DC_LINE_BITS-1:0] fill_line_o,
  // bus
  output logic                     bus_stb_o,
  input  logic                     bus_stb_ack_i,
  output logic                     bus_we_o,
  output logic [`DC_XLEN-1:0]      bus_adr_o,
  output logic [`DC_XLEN-1:0]      bus_d_o,
  input  logic [`DC_XLEN-1:0]      bus_q_i,
  input  logic                     bus_ack_i
);

  localparam logic [1:0] st_idle     = 2'd0;
  localparam logic [1:0] st_wait_stb = 2'd1;   // strobe held till accepted
  localparam logic [1:0] st_burst    = 2'd2;
  localparam logic [1:0] st_ack      = 2'd3;   // ack held till req drops

  logic [1:0]               state_q;
  logic [`DC_BEAT_BITS-1:0] beat_q;            // beats left minus one
  logic                     we_q;
  logic [`DC_XLEN-1:0]      adr_q;
  logic [`DC_LINE_BITS-1:0] sr_q;              // word 0 at the bottom

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= st_idle;
      beat_q  <= '0;
      we_q    <= 1'b0;
    end
    else
    begin
      case (state_q)
        st_idle:
        begin
          if (burst_req_i)
          begin
            we_q    <= burst_we_i;
            beat_q  <= `DC_BEAT_BITS'(`DC_BEATS - 1);
            state_q <= st_wait_stb;
          end
        end
        st_wait_stb: if (bus_stb_ack_i) state_q <= st_burst;
        st_burst:
        begin
          if (bus_ack_i)
          begin
            beat_q <= beat_q - 1'b1;
            if (beat_q == '0)
              state_q <= st_ack;             // last beat taken
          end
        end
        default:     if (!burst_req_i) state_q <= st_idle;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // line shift register, one word per beat
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (state_q == st_idle && burst_req_i)
    begin
      adr_q <= burst_adr_i;                  // block base
      if (burst_we_i)
        sr_q <= victim_line_i;
    end
    else if (state_q == st_burst && bus_ack_i)
      sr_q <= {bus_q_i, sr_q[`DC_LINE_BITS-1:`DC_XLEN]};  // read word in at top
  end

  assign bus_stb_o   = (state_q == st_wait_stb);
  assign bus_we_o    = we_q;
  assign bus_adr_o   = adr_q;
  assign bus_d_o     = sr_q[`DC_XLEN-1:0];   // next write word
  assign burst_ack_o = (state_q == st_ack);
  assign fill_line_o = sr_q;

endmodule

/* verilog/dcache_ctrl.sv */
`include "dcache_consts.svh"

module dcache_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // cpu side, one access at a time
  input  logic                        cpu_req_i,
  input  logic [`DC_XLEN-1:0]         cpu_adr_i,
  input  logic                        cpu_we_i,
  input  logic [`DC_XLEN/8-1:0]       cpu_be_i,
  input  logic [`DC_XLEN-1:0]         cpu_d_i,
  output logic [`DC_XLEN-1:0]         cpu_q_o,
  output logic                        cpu_ack_o,
  // array controls
  output logic [`DC_IDX_BITS-1:0]     lookup_idx_o,
  output logic [`DC_TAG_BITS-1:0]     lookup_tag_o,
  output logic [`DC_BEAT_BITS-1:0]    word_off_o,
  output logic [`DC_XLEN/8-1:0]       be_o,
  output logic [`DC_XLEN-1:0]         wdata_o,
  output logic                        tag_we_o,     // tag, valid, clean into victim way
  output logic                        dirty_we_o,   // set dirty in hit way
  output logic [`DC_WAYS-1:0]         word_we_o,
  output logic [`DC_WAYS-1:0]         line_we_o,
  output logic                        lfsr_hold_o,
  input  logic                        hit_i,
  input  logic [$clog2(`DC_WAYS)-1:0] hit_way_i,
  input  logic [$clog2(`DC_WAYS)-1:0] victim_way_i,
  input  logic                        victim_dirty_i,
  input  logic [`DC_TAG_BITS-1:0]     victim_tag_i,
  input  logic [`DC_XLEN-1:0]         rdata_i,
  // burst unit handshake
  output logic                        burst_req_o,
  output logic                        burst_we_o,
  output logic [`DC_XLEN-1:0]         burst_adr_o,
  input  logic                        burst_ack_i
);

  localparam logic [2:0] st_idle    = 3'd0;
  localparam logic [2:0] st_lookup  = 3'd1;   // arrays read the index
  localparam logic [2:0] st_compare = 3'd2;   // hit known here
  localparam logic [2:0] st_wb      = 3'd3;   // dirty victim out
  localparam logic [2:0] st_fill    = 3'd4;   // new block in
  localparam logic [2:0] st_done    = 3'd5;   // ack up until req drops

  logic [2:0]            state_q;
  dcache_pkg::dc_addr_u  adr_q;
  dcache_pkg::dc_addr_u  wb_adr;     // victim block base
  logic                  we_q;
  logic [`DC_XLEN/8-1:0] be_q;
  logic [`DC_XLEN-1:0]   d_q;
  logic                  miss_q;     // set from first miss to final hit
  logic                  wr_hit;
  logic                  fill_end;

  // ----------------------------------------------------------------------
  // request capture
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (state_q == st_idle && cpu_req_i)
    begin
      adr_q.a <= cpu_adr_i;
      we_q    <= cpu_we_i;
      be_q    <= cpu_be_i;
      d_q     <= cpu_d_i;
    end
    if (state_q == st_done && !cpu_ack_o)
      cpu_q_o <= rdata_i;                 // word of hit way, held under ack
  end

  // lookup fields from the split view
  assign lookup_idx_o = adr_q.f.idx;
  assign lookup_tag_o = adr_q.f.tag;
  assign word_off_o   = adr_q.f.word;
  assign be_o         = be_q;
  assign wdata_o      = d_q;

  // ----------------------------------------------------------------------
  // access fsm
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q     <= st_idle;
      cpu_ack_o   <= 1'b0;
      burst_req_o <= 1'b0;
      miss_q      <= 1'b0;
    end
    else
    begin
      case (state_q)
        st_idle:    if (cpu_req_i) state_q <= st_lookup;
        st_lookup:  state_q <= st_compare;
        st_compare:
        begin
          miss_q <= ~hit_i;
          if (hit_i)
            state_q <= st_done;
          else
          begin
            burst_req_o <= 1'b1;          // write-back first if victim dirty
            state_q     <= victim_dirty_i ? st_wb : st_fill;
          end
        end
        st_wb:
        begin
          if (burst_req_o && burst_ack_i)
            burst_req_o <= 1'b0;
          else if (!burst_req_o && !burst_ack_i)
          begin
            burst_req_o <= 1'b1;          // unit idle again, start fill
            state_q     <= st_fill;
          end
        end
        st_fill:
        begin
          if (fill_end)
            burst_req_o <= 1'b0;
          else if (!burst_req_o && !burst_ack_i)
            state_q <= st_lookup;         // look again, completes as hit
        end
        st_done:
        begin
          if (!cpu_ack_o)
            cpu_ack_o <= 1'b1;
          else if (!cpu_req_i)
          begin
            cpu_ack_o <= 1'b0;
            state_q   <= st_idle;
          end
        end
        default:    state_q <= st_idle;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // array strobes
  // ----------------------------------------------------------------------
  assign wr_hit   = (state_q == st_compare) & hit_i & we_q;
  assign fill_end = (state_q == st_fill) & burst_req_o & burst_ack_i;  // fill line valid

  assign dirty_we_o  = wr_hit;
  assign word_we_o   = {`DC_WAYS{wr_hit}} & (`DC_WAYS'(1) << hit_way_i);
  assign tag_we_o    = fill_end;
  assign line_we_o   = {`DC_WAYS{fill_end}} & (`DC_WAYS'(1) << victim_way_i);
  assign lfsr_hold_o = miss_q | ((state_q == st_compare) & ~hit_i);

  // victim base from stored tag, fill base from the flat address
  always_comb
  begin
    wb_adr.f.tag      = victim_tag_i;
    wb_adr.f.idx      = adr_q.f.idx;
    wb_adr.f.word     = '0;
    wb_adr.f.byte_off = '0;
  end

  assign burst_we_o  = (state_q == st_wb);
  assign burst_adr_o = burst_we_o ? wb_adr.a
                                  : {adr_q.a[`DC_XLEN-1:`DC_OFF_BITS], {`DC_OFF_BITS{1'b0}}};

endmodule

/* verilog/dcache_top.sv */
`include "dcache_consts.svh"

module dcache_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // cpu side
  input  logic                      cpu_req_i,
  input  logic [`DC_XLEN-1:0]       cpu_adr_i,
  input  logic                      cpu_we_i,
  input  logic [`DC_XLEN/8-1:0]     cpu_be_i,
  input  logic [`DC_XLEN-1:0]       cpu_d_i,
  output logic [`DC_XLEN-1:0]       cpu_q_o,
  output logic                      cpu_ack_o,
  // bus side
  output logic                      bus_stb_o,
  input  logic                      bus_stb_ack_i,
  output logic                      bus_we_o,
  output logic [`DC_XLEN-1:0]       bus_adr_o,
  output logic [`DC_XLEN-1:0]       bus_d_o,
  input  logic [`DC_XLEN-1:0]       bus_q_i,
  input  logic                      bus_ack_i
);

  // lookup and write controls
  logic [`DC_IDX_BITS-1:0]          lookup_idx;
  logic [`DC_TAG_BITS-1:0]          lookup_tag;
  logic [`DC_BEAT_BITS-1:0]         word_off;
  logic [`DC_XLEN/8-1:0]            be;
  logic [`DC_XLEN-1:0]              wdata;
  logic                             tag_we;
  logic                             dirty_we;
  logic [`DC_WAYS-1:0]              word_we;
  logic [`DC_WAYS-1:0]              line_we;
  logic                             lfsr_hold;

  // tag array results
  logic                             hit;
  logic [$clog2(`DC_WAYS)-1:0]      hit_way;     // hit way, else victim
  logic [$clog2(`DC_WAYS)-1:0]      victim_way;
  logic                             victim_dirty;
  logic [`DC_TAG_BITS-1:0]          victim_tag;

  // data array and burst unit
  logic [`DC_XLEN-1:0]              rdata;
  logic [`DC_LINE_BITS-1:0]         victim_line;
  logic [`DC_LINE_BITS-1:0]         fill_line;
  logic                             burst_req;
  logic                             burst_we;
  logic                             burst_ack;
  dcache_pkg::dc_addr_u             burst_adr;   // always block aligned

  dcache_ctrl u_ctrl (
    .clk_i, .rst_ni,
    .cpu_req_i, .cpu_adr_i, .cpu_we_i, .cpu_be_i, .cpu_d_i, .cpu_q_o, .cpu_ack_o,
    .lookup_idx_o (lookup_idx),  .lookup_tag_o   (lookup_tag),
    .word_off_o   (word_off),    .be_o           (be),
    .wdata_o      (wdata),       .tag_we_o       (tag_we),
    .dirty_we_o   (dirty_we),    .word_we_o      (word_we),
    .line_we_o    (line_we),     .lfsr_hold_o    (lfsr_hold),
    .hit_i        (hit),         .hit_way_i      (hit_way),
    .victim_way_i (victim_way),  .victim_dirty_i (victim_dirty),
    .victim_tag_i (victim_tag),  .rdata_i        (rdata),
    .burst_req_o  (burst_req),   .burst_we_o     (burst_we),
    .burst_adr_o  (burst_adr),   .burst_ack_i    (burst_ack)
  );

  dcache_tag_array u_tag (
    .clk_i, .rst_ni,
    .lookup_idx_i (lookup_idx),  .lookup_tag_i   (lookup_tag),
    .tag_we_i     (tag_we),      .dirty_we_i     (dirty_we),
    .lfsr_hold_i  (lfsr_hold),   .victim_way_i   (victim_way),
    .hit_o        (hit),         .hit_way_o      (hit_way),
    .victim_way_o (victim_way),  .victim_dirty_o (victim_dirty),
    .victim_tag_o (victim_tag)
  );

  dcache_data_array u_data (
    .clk_i,
    .idx_i     (lookup_idx),  .way_i         (hit_way),
    .word_off_i(word_off),    .be_i          (be),
    .wdata_i   (wdata),       .word_we_i     (word_we),
    .line_we_i (line_we),     .line_i        (fill_line),
    .rdata_o   (rdata),       .victim_line_o (victim_line)
  );

  dcache_burst_unit u_burst (
    .clk_i, .rst_ni,
    .burst_req_i  (burst_req),   .burst_we_i  (burst_we),
    .burst_adr_i  (burst_adr),   .victim_line_i (victim_line),
    .burst_ack_o  (burst_ack),   .fill_line_o (fill_line),
    .bus_stb_o, .bus_stb_ack_i, .bus_we_o, .bus_adr_o, .bus_d_o, .bus_q_i, .bus_ack_i
  );

endmodule

/* sim/tb_dcache.sv */
`include "dcache_consts.svh"

module tb_dcache;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] TB_SEED  = 32'd99403;
  localparam int          CLK_PER  = 100;
  localparam int          STIM_DLY = 10;      // drive point after rising edge
  localparam int          N_TRANS  = 400;
  localparam int          TIMEOUT  = 2000;    // cycles per wait
  localparam logic [31:0] PAT      = 32'h5a3c_96e1;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  cpu_req_i;
  logic [`DC_XLEN-1:0]   cpu_adr_i;
  logic                  cpu_we_i;
  logic [`DC_XLEN/8-1:0] cpu_be_i;
  logic [`DC_XLEN-1:0]   cpu_d_i;
  logic [`DC_XLEN-1:0]   cpu_q_o;
  logic                  cpu_ack_o;
  logic                  bus_stb_o;
  logic                  bus_stb_ack_i;
  logic                  bus_we_o;
  logic [`DC_XLEN-1:0]   bus_adr_o;
  logic [`DC_XLEN-1:0]   bus_d_o;
  logic [`DC_XLEN-1:0]   bus_q_i;
  logic                  bus_ack_i;

  logic [31:0] store [logic [31:0]];    // backing memory by word address
  logic [31:0] model [logic [31:0]];    // what the cpu should read
  bit          written [logic [31:0]];  // block bases the cpu wrote
  logic [31:0] rng_cpu = TB_SEED;
  logic [31:0] rng_bus = TB_SEED ^ 32'h0000_9e37;  // own stream for the bus side
  int          errors = 0;
  int          timeouts = 0;
  bit          aborted = 1'b0;
  logic        ack_d = 1'b0;
  logic        req_d = 1'b0;

  dcache_top dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PER/2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] fill_pattern(input logic [31:0] a);
    return a ^ PAT;                     // unwritten memory
  endfunction

  function automatic logic [31:0] store_word(input logic [31:0] a);
    return store.exists(a) ? store[a] : fill_pattern(a);
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] a);
    return model.exists(a) ? model[a] : fill_pattern(a);
  endfunction

  // 4 tags x 4 sets x 4 words so two ways overflow
  function automatic logic [31:0] pick_addr(input logic [31:0] r);
    return {16'h00a5, 6'd0, r[1:0], 2'b00, r[3:2], r[5:4], 2'b00};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] be);
    logic [31:0] m;
    m = old;
    for (int b = 0; b < 4; b++)
    begin
      if (be[b])
        m[b*8 +: 8] = d[b*8 +: 8];
    end
    return m;
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #STIM_DLY;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic idle_bus();
    int n;
    rng_bus = xorshift(rng_bus);
    n = int'(rng_bus[1:0]);             // 0 to 3 idle cycles
    repeat (n) tick();
  endtask

  // ----------------------------------------------------------------------
  // one four-phase cpu access
  // ----------------------------------------------------------------------
  task automatic cpu_access(input logic we, input logic [31:0] adr, input logic [3:0] be,
                            input logic [31:0] d, output logic [31:0] q,
                            output int edges, output bit saw_stb);
    int n;
    int hold;
    cpu_adr_i = adr;
    cpu_we_i  = we;
    cpu_be_i  = be;
    cpu_d_i   = d;
    cpu_req_i = 1'b1;
    edges     = 0;
    saw_stb   = 1'b0;
    q         = 'x;
    while (cpu_ack_o !== 1'b1 && edges < TIMEOUT)
    begin
      tick();
      edges++;
      if (bus_stb_o === 1'b1)
        saw_stb = 1'b1;
    end
    if (cpu_ack_o !== 1'b1)
    begin
      timeouts++;
      aborted = 1'b1;
      $display("timeout at %0t: no cpu_ack_o for access to %h", $time, adr);
    end
    else
    begin
      rng_cpu = xorshift(rng_cpu);
      hold    = int'(rng_cpu[1:0]);     // req stays up a few cycles past ack
      repeat (hold) tick();
      q         = cpu_q_o;              // still held while ack high
      cpu_req_i = 1'b0;
      n         = 0;
      while (cpu_ack_o !== 1'b0 && n < TIMEOUT)
      begin
        tick();
        n++;
      end
      if (cpu_ack_o !== 1'b0)
      begin
        timeouts++;
        aborted = 1'b1;
        $display("timeout at %0t: cpu_ack_o stuck high after req dropped", $time);
      end
    end
  endtask

  // ack may only fall once req was seen low
  always @(negedge clk_i)
  begin
    if (rst_ni && ack_d && !cpu_ack_o && req_d)
    begin
      errors++;
      $display("cpu_ack_o fell at %0t while cpu_req_i was still high", $time);
    end
    ack_d = cpu_ack_o;
    req_d = cpu_req_i;
  end

  // ----------------------------------------------------------------------
  // bus responder with random stalls
  // ----------------------------------------------------------------------
  initial
  begin : bus_responder
    logic [31:0] base;
    logic [31:0] a;
    logic        wr;
    bus_stb_ack_i = 1'b0;
    bus_ack_i     = 1'b0;
    bus_q_i       = '0;
    forever
    begin
      tick();
      if (bus_stb_o === 1'b1)
      begin
        base = bus_adr_o;
        wr   = bus_we_o;
        check_val("bus_adr_o[3:0]", 32'(base[3:0]), 32'h0);
        if (wr && !written.exists(base))
        begin
          errors++;
          $display("write-back at %0t of block %h that the cpu never wrote", $time, base);
        end
        idle_bus();
        bus_stb_ack_i = 1'b1;
        tick();
        bus_stb_ack_i = 1'b0;
        for (int b = 0; b < `DC_BEATS; b++)
        begin
          idle_bus();
          a         = base + 32'(4 * b);
          bus_ack_i = 1'b1;
          if (wr)
          begin
            check_val("bus_d_o", bus_d_o, model_word(a));  // dirty data leaves intact
            store[a] = bus_d_o;
          end
          else
            bus_q_i = store_word(a);
          tick();
          bus_ack_i = 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial
  begin : main_seq
    logic [31:0] adr;
    logic [31:0] wdat;
    logic [31:0] q;
    logic [3:0]  be;
    int          edges;
    bit          saw_stb;
    bit          again;
    rst_ni    = 1'b0;
    cpu_req_i = 1'b0;
    cpu_adr_i = '0;
    cpu_we_i  = 1'b0;
    cpu_be_i  = '0;
    cpu_d_i   = '0;
    repeat (2) @(posedge clk_i);
    #STIM_DLY;
    rst_ni = 1'b1;
    tick();
    check_val("cpu_ack_o", 32'(cpu_ack_o), 32'h0);
    check_val("bus_stb_o", 32'(bus_stb_o), 32'h0);

    for (int i = 0; i < N_TRANS && !aborted; i++)
    begin
      rng_cpu = xorshift(rng_cpu);
      adr     = pick_addr(rng_cpu);
      if (rng_cpu[8])
      begin
        rng_cpu = xorshift(rng_cpu);
        wdat    = rng_cpu;
        rng_cpu = xorshift(rng_cpu);
        be      = rng_cpu[3:0];
        cpu_access(1'b1, adr, be, wdat, q, edges, saw_stb);
        if (!aborted)
        begin
          model[adr] = merge_bytes(model_word(adr), wdat, be);
          written[{adr[31:4], 4'h0}] = 1'b1;
        end
        again = 1'b1;                   // always read a write back
      end
      else
      begin
        cpu_access(1'b0, adr, 4'h0, 32'h0, q, edges, saw_stb);
        if (!aborted)
          check_val("cpu_q_o", q, model_word(adr));
        again = rng_cpu[9];
      end
      // block is resident now so this is a plain hit
      if (again && !aborted)
      begin
        cpu_access(1'b0, adr, 4'h0, 32'h0, q, edges, saw_stb);
        if (!aborted)
        begin
          check_val("cpu_q_o", q, model_word(adr));
          check_val("hit latency", 32'(edges - 1), 32'd3);
          check_val("bus_stb_o on hit", 32'(saw_stb), 32'h0);
        end
      end
    end

    $display("errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* src.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_burst_unit.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/tb_dcache.sv

/* Makefile */
# Verilator simulation of the data cache testbench

TOP := tb_dcache

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, write sim.log, fail on a failing run"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --top-module $(TOP) -f src.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then \
	  echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
